// File: Makefile
# Verilator lint and simulation of the acquisition block

TOOL  := verilator
FLAGS := --timing
TOP   := acq_tb
FLIST := sim.f
BUILD := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(TOOL) --binary $(FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP)

clean:
	rm -rf $(BUILD)

// File: hw/acq_ctrl.sv
// acquire controller
// start/trigger/stop state, pre and post trigger counters, timestamps,
// interrupts and a one-stage output register for any payload type

`timescale 1ns/100ps

module acq_ctrl import acq_pkg::*; #(
  parameter type dat_t = smp_t
)(
  input  logic          sti,
  input  logic          ctl_rst,
  // input stream
  input  logic          in_vld,
  input  dat_t          in_beat,
  input  logic          in_lst,
  output logic          in_rdy,
  // output stream
  output logic          out_vld,
  output dat_t          out_beat,
  output logic          out_lst,
  input  logic          out_rdy,
  // time and trigger sources
  input  logic [tw-1:0] cts,
  input  logic [tn-1:0] src_trg,
  // registers
  input  cfg_t          cfg,
  input  cmd_t          cmd,
  output sts_t          sts,
  // interrupts
  output logic          irq_trg,
  output logic          irq_stp
);

  logic          acq;
  logic          trg;
  logic          ena_pre;
  logic          xfer;
  logic          fire;
  logic          stop;
  logic          end_cnt;
  logic [cw-1:0] cnt_pre;
  logic [cw-1:0] cnt_pst;
  logic [cw-1:0] nxt_pre;
  logic [cw-1:0] nxt_pst;
  logic [tw-1:0] cts_acq;
  logic [tw-1:0] cts_trg;
  logic [tw-1:0] cts_stp;

  ////////////////////////////////////////
  // trigger and stop conditions
  ////////////////////////////////////////

  // input handshake, the only place a transfer is decided
  assign in_rdy = out_rdy | ~out_vld;
  assign xfer   = in_vld & in_rdy;

  assign nxt_pre = cnt_pre + 1'b1;
  assign nxt_pst = cnt_pst + 1'b1;

  // masked sources, only while armed and not yet triggered
  assign fire = (|(src_trg & cfg.trg)) & acq & ena_pre & ~trg;

  // beat that completes the post count
  assign end_cnt = xfer & (trg | fire) & ~cfg.con & (nxt_pst == cfg.pst);

  assign stop = acq & (cmd.stp | (xfer & in_lst) | end_cnt);

  assign irq_trg = fire;
  assign irq_stp = stop;

  ////////////////////////////////////////
  // acquire state
  ////////////////////////////////////////

  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      acq     <= 1'b0;
      trg     <= 1'b0;
      ena_pre <= 1'b0;
      cnt_pre <= '0;
      cnt_pst <= '0;
      cts_acq <= '0;
      cts_trg <= '0;
      cts_stp <= '0;
    end else begin
      // counters, triggering beat lands in both
      if (acq & xfer) begin
        if (~trg) begin
          cnt_pre <= nxt_pre;
          if (nxt_pre == cfg.pre)
            ena_pre <= 1'b1;
        end
        if (trg | fire)
          cnt_pst <= nxt_pst;
      end
      if (fire) begin
        trg     <= 1'b1;
        cts_trg <= cts;
      end
      // stop wins over start, start overrides the counters
      if (stop) begin
        acq     <= 1'b0;
        cts_stp <= cts;
      end else if (cmd.acq) begin
        acq     <= 1'b1;
        trg     <= cfg.aut;
        ena_pre <= ~|cfg.pre;
        cnt_pre <= '0;
        cnt_pst <= '0;
        cts_acq <= cts;
      end
    end
  end

  ////////////////////////////////////////
  // output register
  ////////////////////////////////////////

  // loads only while the input side is ready
  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      out_vld <= 1'b0;
      out_lst <= 1'b0;
    end else if (in_rdy) begin
      out_vld <= acq & in_vld;
      out_lst <= acq & in_vld & (in_lst | end_cnt);
    end
  end

  // payload, no reset
  always_ff @(posedge sti) begin
    if (in_rdy & acq & in_vld)
      out_beat <= in_beat;
  end

  // status out
  assign sts.acq     = acq;
  assign sts.trg     = trg;
  assign sts.xfr     = xfer;
  assign sts.pre     = cnt_pre;
  assign sts.pst     = cnt_pst;
  assign sts.cts_acq = cts_acq;
  assign sts.cts_trg = cts_trg;
  assign sts.cts_stp = cts_stp;

endmodule : acq_ctrl

// File: hw/acq_pkg.sv
// acquisition package
// shared widths, register map and the packed stream, configuration,
// command and status types of the acquire block

package acq_pkg;

  // widths
  localparam int unsigned dw = 16;
  localparam int unsigned tn = 3;
  localparam int unsigned tw = 32;
  localparam int unsigned cw = 16;
  localparam int unsigned aw = 4;
  localparam int unsigned rw = 32;

  ////////////////////////////////////////
  // register map (word addresses)
  ////////////////////////////////////////

  localparam logic [aw-1:0] reg_ctl     = 4'd0;
  localparam logic [aw-1:0] reg_mode    = 4'd1;
  localparam logic [aw-1:0] reg_pre     = 4'd2;
  localparam logic [aw-1:0] reg_pst     = 4'd3;
  localparam logic [aw-1:0] reg_lvl     = 4'd4;
  localparam logic [aw-1:0] reg_sts     = 4'd5;
  localparam logic [aw-1:0] reg_cnt_pre = 4'd6;
  localparam logic [aw-1:0] reg_cnt_pst = 4'd7;
  localparam logic [aw-1:0] reg_cts_acq = 4'd8;
  localparam logic [aw-1:0] reg_cts_trg = 4'd9;
  localparam logic [aw-1:0] reg_cts_stp = 4'd10;
  localparam logic [aw-1:0] reg_time    = 4'd11;

  ////////////////////////////////////////
  // packed types
  ////////////////////////////////////////

  // stream beat, signed sample plus last flag
  typedef struct packed {
    logic signed [dw-1:0] dat;
    logic                 lst;
  } smp_t;

  // trigger mask bit 0 edge, bit 1 software, bit 2 external
  typedef struct packed {
    logic [tn-1:0]        trg;
    logic                 con;
    logic                 aut;
    logic [cw-1:0]        pre;
    logic [cw-1:0]        pst;
    logic signed [dw-1:0] lvl;
  } cfg_t;

  // one-cycle command strobes
  typedef struct packed {
    logic acq;
    logic stp;
    logic trg;
  } cmd_t;

  // controller status, xfr is the input transfer strobe
  typedef struct packed {
    logic          acq;
    logic          trg;
    logic          xfr;
    logic [cw-1:0] pre;
    logic [cw-1:0] pst;
    logic [tw-1:0] cts_acq;
    logic [tw-1:0] cts_trg;
    logic [tw-1:0] cts_stp;
  } sts_t;

endpackage : acq_pkg

// File: hw/acq_regs.sv
// acquire register block
// configuration registers, command strobes, status readback
// and the free-running time counter

`timescale 1ns/100ps

module acq_regs import acq_pkg::*; (
  input  logic          sti,
  input  logic          ctl_rst,
  // register port
  input  logic          reg_wen,
  input  logic          reg_ren,
  input  logic [aw-1:0] reg_addr,
  input  logic [rw-1:0] reg_wdata,
  output logic [rw-1:0] reg_rdata,
  // towards the controller
  output cfg_t          cfg,
  output cmd_t          cmd,
  input  sts_t          sts,
  output logic [tw-1:0] cts
);

  logic [rw-1:0] rd_mux;

  ////////////////////////////////////////
  // configuration
  ////////////////////////////////////////

  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      cfg <= '0;
    end else if (reg_wen) begin
      case (reg_addr)
        reg_mode: begin
          cfg.trg <= reg_wdata[tn-1:0];
          cfg.con <= reg_wdata[3];
          cfg.aut <= reg_wdata[4];
        end
        reg_pre: cfg.pre <= reg_wdata[cw-1:0];
        reg_pst: cfg.pst <= reg_wdata[cw-1:0];
        reg_lvl: cfg.lvl <= reg_wdata[dw-1:0];
        default: ;
      endcase
    end
  end

  // command bits become single cycle strobes
  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      cmd <= '0;
    end else begin
      cmd.acq <= reg_wen & (reg_addr == reg_ctl) & reg_wdata[0];
      cmd.stp <= reg_wen & (reg_addr == reg_ctl) & reg_wdata[1];
      cmd.trg <= reg_wen & (reg_addr == reg_ctl) & reg_wdata[2];
    end
  end

  // free-running time
  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      cts <= '0;
    end else begin
      cts <= cts + 1'b1;
    end
  end

  ////////////////////////////////////////
  // read back
  ////////////////////////////////////////

  always_comb begin
    rd_mux = '0;
    case (reg_addr)
      reg_mode:    rd_mux = rw'({cfg.aut, cfg.con, cfg.trg});
      reg_pre:     rd_mux = rw'(cfg.pre);
      reg_pst:     rd_mux = rw'(cfg.pst);
      // level reads back zero extended
      reg_lvl:     rd_mux = rw'(unsigned'(cfg.lvl));
      reg_sts:     rd_mux = rw'({sts.trg, sts.acq});
      reg_cnt_pre: rd_mux = rw'(sts.pre);
      reg_cnt_pst: rd_mux = rw'(sts.pst);
      reg_cts_acq: rd_mux = sts.cts_acq;
      reg_cts_trg: rd_mux = sts.cts_trg;
      reg_cts_stp: rd_mux = sts.cts_stp;
      reg_time:    rd_mux = cts;
      default:     rd_mux = '0;
    endcase
  end

  // data held until the next read
  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      reg_rdata <= '0;
    end else if (reg_ren) begin
      reg_rdata <= rd_mux;
    end
  end

endmodule : acq_regs

// File: hw/acq_top.sv
// acquisition top
// register block, level-crossing trigger and acquire controller

`timescale 1ns/100ps

module acq_top import acq_pkg::*; (
  input  logic          sti,
  input  logic          ctl_rst,
  // input stream
  input  logic          in_vld,
  input  smp_t          in_beat,
  output logic          in_rdy,
  // output stream
  output logic          out_vld,
  output smp_t          out_beat,
  input  logic          out_rdy,
  // external trigger pin
  input  logic          ext_trg,
  // register port
  input  logic          reg_wen,
  input  logic          reg_ren,
  input  logic [aw-1:0] reg_addr,
  input  logic [rw-1:0] reg_wdata,
  output logic [rw-1:0] reg_rdata,
  // interrupts
  output logic          irq_trg,
  output logic          irq_stp
);

  cfg_t          cfg;
  cmd_t          cmd;
  sts_t          sts;
  logic [tw-1:0] cts;
  logic          edge_pls;
  logic [tn-1:0] src_trg;
  smp_t          beat_o;
  logic          lst_o;

  // bit 0 edge, bit 1 software, bit 2 external
  assign src_trg = {ext_trg, cmd.trg, edge_pls};

  // last flag from the controller replaces the forwarded one
  assign out_beat = '{dat: beat_o.dat, lst: lst_o};

  acq_regs acq_regs_inst (
    .sti       (sti),
    .ctl_rst   (ctl_rst),
    .reg_wen   (reg_wen),
    .reg_ren   (reg_ren),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .cfg       (cfg),
    .cmd       (cmd),
    .sts       (sts),
    .cts       (cts)
  );

  trg_edge trg_edge_inst (
    .sti     (sti),
    .ctl_rst (ctl_rst),
    .beat    (in_beat),
    .xfer    (sts.xfr),
    .lvl     (cfg.lvl),
    .pulse   (edge_pls)
  );

  acq_ctrl #(
    .dat_t (smp_t)
  ) acq_ctrl_inst (
    .sti      (sti),
    .ctl_rst  (ctl_rst),
    .in_vld   (in_vld),
    .in_beat  (in_beat),
    .in_lst   (in_beat.lst),
    .in_rdy   (in_rdy),
    .out_vld  (out_vld),
    .out_beat (beat_o),
    .out_lst  (lst_o),
    .out_rdy  (out_rdy),
    .cts      (cts),
    .src_trg  (src_trg),
    .cfg      (cfg),
    .cmd      (cmd),
    .sts      (sts),
    .irq_trg  (irq_trg),
    .irq_stp  (irq_stp)
  );

endmodule : acq_top

// File: hw/trg_edge.sv
// level-crossing trigger
// pulses on a transferred sample at or above the level when the
// previous transferred sample was below it

`timescale 1ns/100ps

module trg_edge import acq_pkg::*; (
  input  logic                 sti,
  input  logic                 ctl_rst,
  input  smp_t                 beat,
  input  logic                 xfer,
  input  logic signed [dw-1:0] lvl,
  output logic                 pulse
);

  // most negative sample, so the first sample can cross
  localparam logic signed [dw-1:0] smp_min = {1'b1, {(dw-1){1'b0}}};

  logic signed [dw-1:0] prv;
  logic                 cur_hi;
  logic                 prv_lo;

  // signed compares against the level
  assign cur_hi = (beat.dat >= lvl);
  assign prv_lo = (prv < lvl);

  // same cycle as the crossing beat
  assign pulse = xfer & cur_hi & prv_lo;

  // previous sample only moves on a transfer
  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      prv <= smp_min;
    end else if (xfer) begin
      prv <= beat.dat;
    end
  end

endmodule : trg_edge

// File: sim.f
hw/acq_pkg.sv
hw/acq_regs.sv
hw/trg_edge.sv
hw/acq_ctrl.sv
hw/acq_top.sv
verif/acq_tb.sv

// File: verif/acq_tb.sv
// acquisition testbench
// random walk stream with back-pressure, register sequences and a
// cycle model of the trigger, counters, timestamps and output stream

`timescale 1ns/100ps

module acq_tb import acq_pkg::*; ();

  // planned stream beats, sets the watchdog
  localparam int n_beats   = 700;
  localparam int wd_cycles = n_beats * 20 + 2000;
  localparam int max_wait  = 1500;

  logic          sti = 1'b0;
  logic          ctl_rst;
  logic          in_vld;
  smp_t          in_beat;
  logic          in_rdy;
  logic          out_vld;
  smp_t          out_beat;
  logic          out_rdy;
  logic          ext_trg;
  logic          reg_wen;
  logic          reg_ren;
  logic [aw-1:0] reg_addr;
  logic [rw-1:0] reg_wdata;
  logic [rw-1:0] reg_rdata;
  logic          irq_trg;
  logic          irq_stp;

  // stimulus state
  logic [31:0]          seed;
  logic signed [dw-1:0] walk;
  logic                 last_xf;
  logic                 stream_on;
  logic                 bp_on;
  logic                 lst_on;
  logic                 ext_on;
  logic [rw-1:0]        old_ts;

  // model state
  cfg_t                 m_cfg;
  cmd_t                 m_cmd;
  logic                 m_acq;
  logic                 m_trg;
  logic                 m_ena;
  logic [cw-1:0]        m_pre;
  logic [cw-1:0]        m_pst;
  logic [tw-1:0]        m_cts;
  logic [tw-1:0]        m_cts_acq;
  logic [tw-1:0]        m_cts_trg;
  logic [tw-1:0]        m_cts_stp;
  logic signed [dw-1:0] m_prv;
  logic                 m_ovld;
  logic [rw-1:0]        m_rdata;
  smp_t                 exp_q[$];

  acq_top acq_top_inst (
    .sti       (sti),
    .ctl_rst   (ctl_rst),
    .in_vld    (in_vld),
    .in_beat   (in_beat),
    .in_rdy    (in_rdy),
    .out_vld   (out_vld),
    .out_beat  (out_beat),
    .out_rdy   (out_rdy),
    .ext_trg   (ext_trg),
    .reg_wen   (reg_wen),
    .reg_ren   (reg_ren),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .irq_trg   (irq_trg),
    .irq_stp   (irq_stp)
  );

  // 8 ns period
  always #4 sti = ~sti;

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic logic [31:0] rand_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic fail_run(input string msg);
    $display("error at %0t: %s", $time, msg);
    $display("*** FAILED ***");
    $fatal(1, "run stopped on error");
  endtask

  task automatic check_eq(input string what, input logic [31:0] got,
                          input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp);
      $display("*** FAILED ***");
      $fatal(1, "value mismatch");
    end
  endtask

  // register map as the model sees it
  function automatic logic [rw-1:0] read_value(input logic [aw-1:0] addr);
    case (addr)
      reg_mode:    return {27'd0, m_cfg.aut, m_cfg.con, m_cfg.trg};
      reg_pre:     return {16'd0, m_cfg.pre};
      reg_pst:     return {16'd0, m_cfg.pst};
      reg_lvl:     return {16'd0, m_cfg.lvl};
      reg_sts:     return {30'd0, m_trg, m_acq};
      reg_cnt_pre: return {16'd0, m_pre};
      reg_cnt_pst: return {16'd0, m_pst};
      reg_cts_acq: return m_cts_acq;
      reg_cts_trg: return m_cts_trg;
      reg_cts_stp: return m_cts_stp;
      reg_time:    return m_cts;
      default:     return '0;
    endcase
  endfunction

  ////////////////////////////////////////
  // cycle model
  ////////////////////////////////////////

  task automatic model_step();
    logic          rdy;
    logic          xf;
    logic          pls;
    logic          fire;
    logic          endc;
    logic          stop;
    logic [tn-1:0] src;
    smp_t          exp_beat;
    // what the DUT must show in this cycle
    rdy  = out_rdy | ~m_ovld;
    xf   = in_vld & rdy;
    pls  = xf & (in_beat.dat >= m_cfg.lvl) & (m_prv < m_cfg.lvl);
    src  = {ext_trg, m_cmd.trg, pls};
    fire = (|(src & m_cfg.trg)) & m_acq & m_ena & ~m_trg;
    endc = xf & (m_trg | fire) & ~m_cfg.con & ((m_pst + 1'b1) == m_cfg.pst);
    stop = m_acq & (m_cmd.stp | (xf & in_beat.lst) | endc);
    check_eq("in_rdy", 32'(in_rdy), 32'(rdy));
    check_eq("irq_trg", 32'(irq_trg), 32'(fire));
    check_eq("irq_stp", 32'(irq_stp), 32'(stop));
    check_eq("out_vld", 32'(out_vld), 32'(m_ovld));
    check_eq("reg_rdata", reg_rdata, m_rdata);
    if (m_ovld & out_rdy) begin
      if (exp_q.size() == 0) begin
        fail_run("output beat appeared while none was expected");
      end else begin
        exp_beat = exp_q.pop_front();
        check_eq("out_beat", 32'(out_beat), 32'(exp_beat));
      end
    end
    // state at the closing edge
    if (reg_ren)
      m_rdata = read_value(reg_addr);
    if (rdy) begin
      m_ovld = m_acq & in_vld;
      if (m_acq & in_vld) begin
        exp_beat.dat = in_beat.dat;
        exp_beat.lst = in_beat.lst | endc;
        exp_q.push_back(exp_beat);
      end
    end
    // triggering beat counts as pre and post
    if (m_acq & xf) begin
      if (~m_trg) begin
        m_pre = m_pre + 1'b1;
        if (m_pre == m_cfg.pre)
          m_ena = 1'b1;
      end
      if (m_trg | fire)
        m_pst = m_pst + 1'b1;
    end
    if (fire) begin
      m_trg     = 1'b1;
      m_cts_trg = m_cts;
    end
    if (stop) begin
      m_acq     = 1'b0;
      m_cts_stp = m_cts;
    end else if (m_cmd.acq) begin
      m_acq     = 1'b1;
      m_trg     = m_cfg.aut;
      m_ena     = (m_cfg.pre == '0);
      m_pre     = '0;
      m_pst     = '0;
      m_cts_acq = m_cts;
    end
    if (reg_wen) begin
      case (reg_addr)
        reg_mode: begin
          m_cfg.trg = reg_wdata[tn-1:0];
          m_cfg.con = reg_wdata[3];
          m_cfg.aut = reg_wdata[4];
        end
        reg_pre: m_cfg.pre = reg_wdata[cw-1:0];
        reg_pst: m_cfg.pst = reg_wdata[cw-1:0];
        reg_lvl: m_cfg.lvl = reg_wdata[dw-1:0];
        default: ;
      endcase
    end
    m_cmd.acq = reg_wen & (reg_addr == reg_ctl) & reg_wdata[0];
    m_cmd.stp = reg_wen & (reg_addr == reg_ctl) & reg_wdata[1];
    m_cmd.trg = reg_wen & (reg_addr == reg_ctl) & reg_wdata[2];
    if (xf)
      m_prv = in_beat.dat;
    m_cts   = m_cts + 1'b1;
    last_xf = xf;
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  // called on a falling edge, returns on the next one
  task automatic cycle(input logic wen, input logic ren, input logic [aw-1:0] addr,
                       input logic [rw-1:0] wdata);
    logic [31:0] r;
    // a beat is held until it transfers
    if (!in_vld || last_xf) begin
      r            = rand_next();
      walk         = walk + 16'($signed(r[27:16]));
      in_vld       = stream_on && (r[31:30] != 2'b00);
      in_beat.dat  = walk;
      in_beat.lst  = lst_on && (r[15:10] == 6'd0);
    end
    r         = rand_next();
    out_rdy   = !bp_on || (r[31:30] != 2'b00);
    ext_trg   = ext_on && (r[29:26] == 4'd0);
    reg_wen   = wen;
    reg_ren   = ren;
    reg_addr  = addr;
    reg_wdata = wdata;
    #1;
    model_step();
    @(negedge sti);
  endtask

  task automatic idle(input int n);
    repeat (n) cycle(1'b0, 1'b0, reg_ctl, '0);
  endtask

  task automatic reg_write(input logic [aw-1:0] addr, input logic [rw-1:0] data);
    cycle(1'b1, 1'b0, addr, data);
  endtask

  // read data is registered, so it is valid on return
  task automatic read_expect(input string what, input logic [aw-1:0] addr,
                             input logic [rw-1:0] exp);
    cycle(1'b0, 1'b1, addr, '0);
    check_eq(what, reg_rdata, exp);
  endtask

  task automatic run_until_trig();
    int n;
    n = 0;
    while (!m_trg) begin
      if (n == max_wait)
        fail_run("trigger did not fire in time");
      idle(1);
      n++;
    end
  endtask

  task automatic run_until_stop();
    int n;
    n = 0;
    while (m_acq) begin
      if (n == max_wait)
        fail_run("acquisition did not stop in time");
      idle(1);
      n++;
    end
  endtask

  // start command, acq is set two edges later
  task automatic start_acq();
    reg_write(reg_ctl, 32'h1);
    idle(1);
  endtask

  // watchdog
  initial begin
    repeat (wd_cycles) @(posedge sti);
    fail_run("watchdog expired before the test sequence ended");
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    ctl_rst   = 1'b1;
    in_vld    = 1'b0;
    in_beat   = '0;
    out_rdy   = 1'b0;
    ext_trg   = 1'b0;
    reg_wen   = 1'b0;
    reg_ren   = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    seed      = 32'hfdc0;
    walk      = '0;
    last_xf   = 1'b0;
    stream_on = 1'b1;
    bp_on     = 1'b1;
    lst_on    = 1'b0;
    ext_on    = 1'b0;
    old_ts    = '0;
    // model reset values
    m_cfg     = '0;
    m_cmd     = '0;
    m_acq     = 1'b0;
    m_trg     = 1'b0;
    m_ena     = 1'b0;
    m_pre     = '0;
    m_pst     = '0;
    m_cts     = '0;
    m_cts_acq = '0;
    m_cts_trg = '0;
    m_cts_stp = '0;
    m_prv     = {1'b1, {(dw-1){1'b0}}};
    m_ovld    = 1'b0;
    m_rdata   = '0;
    repeat (8) @(posedge sti);
    @(negedge sti);
    ctl_rst = 1'b0;

    // configuration readback
    reg_write(reg_mode, 32'h01);
    reg_write(reg_pre, 32'd20);
    reg_write(reg_pst, 32'd30);
    reg_write(reg_lvl, 32'h0000_fc00);
    read_expect("mode", reg_mode, 32'h01);
    read_expect("pre", reg_pre, 32'd20);
    read_expect("pst", reg_pst, 32'd30);
    read_expect("negative level", reg_lvl, 32'h0000_fc00);
    read_expect("ctl reads zero", reg_ctl, 32'h0);
    reg_write(reg_lvl, 32'h0000_0400);
    read_expect("level", reg_lvl, 32'h0000_0400);

    // edge trigger after pre beats, stop on post count
    start_acq();
    run_until_trig();
    read_expect("triggered", reg_sts, 32'h3);
    idle(1);
    run_until_stop();
    read_expect("stopped", reg_sts, 32'h2);
    read_expect("post count", reg_cnt_pst, 32'd30);
    read_expect("pre count", reg_cnt_pre, {16'd0, m_pre});
    check_eq("pre count reached", 32'(reg_rdata >= 32'd20), 32'd1);
    idle(1);
    cycle(1'b0, 1'b1, reg_cts_trg, '0);
    cycle(1'b0, 1'b1, reg_cts_stp, '0);
    idle(20);

    // automatic plus continuous, software stop
    reg_write(reg_mode, 32'h18);
    start_acq();
    read_expect("auto armed", reg_sts, 32'h3);
    idle(60);
    read_expect("still running", reg_sts, 32'h3);
    reg_write(reg_ctl, 32'h2);
    idle(1);
    read_expect("software stop", reg_sts, 32'h2);

    // stop on a beat marked last
    lst_on = 1'b1;
    start_acq();
    run_until_stop();
    lst_on = 1'b0;
    read_expect("stop on last", reg_sts, 32'h2);

    // software trigger only, edge and ext masked
    ext_on = 1'b1;
    reg_write(reg_mode, 32'h0a);
    reg_write(reg_pre, 32'd0);
    start_acq();
    idle(80);
    read_expect("masked sources", reg_sts, 32'h1);
    reg_write(reg_ctl, 32'h4);
    idle(1);
    read_expect("software trigger", reg_sts, 32'h3);
    reg_write(reg_ctl, 32'h2);
    idle(2);

    // ext only, software strobe masked
    reg_write(reg_mode, 32'h0c);
    start_acq();
    reg_write(reg_ctl, 32'h4);
    run_until_trig();
    reg_write(reg_ctl, 32'h2);
    idle(2);
    ext_on = 1'b0;

    // restart clears counts and takes a new start time
    stream_on = 1'b0;
    bp_on     = 1'b0;
    idle(4);
    reg_write(reg_mode, 32'h01);
    reg_write(reg_pre, 32'd5);
    reg_write(reg_pst, 32'd10);
    cycle(1'b0, 1'b1, reg_cts_acq, '0);
    old_ts = reg_rdata;
    start_acq();
    read_expect("restart pre", reg_cnt_pre, 32'd0);
    read_expect("restart post", reg_cnt_pst, 32'd0);
    cycle(1'b0, 1'b1, reg_cts_acq, '0);
    check_eq("new start time", 32'(reg_rdata > old_ts), 32'd1);
    stream_on = 1'b1;
    bp_on     = 1'b1;
    run_until_trig();
    idle(1);
    run_until_stop();
    read_expect("restart post end", reg_cnt_pst, 32'd10);

    // drain the output
    stream_on = 1'b0;
    bp_on     = 1'b0;
    idle(6);
    if (exp_q.size() == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      fail_run("expected output beats never appeared");
    end
  end

endmodule : acq_tb
